// File: verilog/mipsPkg.sv
package mipsPkg;

    //////////////////////////////////////////////////
    // Instruction encodings
    //////////////////////////////////////////////////

    // Primary opcode field, bits 31 to 26
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'b000000,
        OP_J       = 6'b000010,
        OP_JAL     = 6'b000011,
        OP_BEQ     = 6'b000100,
        OP_BGTZ    = 6'b000111,
        OP_ORI     = 6'b001101,
        OP_LUI     = 6'b001111,
        OP_LW      = 6'b100011,
        OP_SW      = 6'b101011
    } opcodeE;

    // Function field of SPECIAL, bits 5 to 0
    typedef enum logic [5:0] {
        FN_JR   = 6'b001000,
        FN_ADDU = 6'b100001,
        FN_SUBU = 6'b100011
    } functE;

    // Execute stage operation
    typedef enum logic [1:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_OR,
        ALU_LUI
    } aluOpE;

    // All-zero word is sll $0,$0,0 and doubles as the pipeline bubble
    localparam logic [31:0] INSTR_NOP = 32'h0000_0000;

    // Link register of jal
    localparam logic [4:0] REG_RA = 5'd31;

    localparam int DMEM_WORDS = 64;
    localparam logic [31:0] RESET_PC = 32'h0000_0000;

    //////////////////////////////////////////////////
    // Hazard timing in cycles after decode
    //////////////////////////////////////////////////

    // Use time of a source operand
    localparam logic [1:0] TUSE_BRANCH = 2'd0;
    localparam logic [1:0] TUSE_ALU    = 2'd1;
    localparam logic [1:0] TUSE_STORE  = 2'd2;
    localparam logic [1:0] TUSE_NONE   = 2'd3;

    // Ready time of a result as seen from execute
    localparam logic [1:0] TNEW_ALU  = 2'd1;
    localparam logic [1:0] TNEW_LOAD = 2'd2;

endpackage

// File: verilog/instrDecoder.sv
`timescale 1ns/1ns

module instrDecoder (
    input  logic [31:0]    instr,
    output logic [4:0]     rs,
    output logic [4:0]     rt,
    output logic [4:0]     regAddr,
    output logic           regWrite,
    output logic           calcR,
    output logic           calcI,
    output logic           load,
    output logic           store,
    output logic           lui,
    output logic           beq,
    output logic           bgtz,
    output logic           j,
    output logic           jal,
    output logic           jr,
    output mipsPkg::aluOpE aluOp
);

    mipsPkg::opcodeE opcode;
    mipsPkg::functE  funct;
    logic [4:0]      rd;
    logic            special;
    logic            opKnown;

    // Fixed field positions
    assign opcode = mipsPkg::opcodeE'(instr[31:26]);
    assign funct  = mipsPkg::functE'(instr[5:0]);
    assign rs     = instr[25:21];
    assign rt     = instr[20:16];
    assign rd     = instr[15:11];

    // Class flags
    assign special = (opcode == mipsPkg::OP_SPECIAL);
    assign calcR   = special && (funct == mipsPkg::FN_ADDU || funct == mipsPkg::FN_SUBU);
    assign jr      = special && (funct == mipsPkg::FN_JR);
    assign calcI   = (opcode == mipsPkg::OP_ORI);
    assign lui     = (opcode == mipsPkg::OP_LUI);
    assign load    = (opcode == mipsPkg::OP_LW);
    assign store   = (opcode == mipsPkg::OP_SW);
    assign beq     = (opcode == mipsPkg::OP_BEQ);
    assign bgtz    = (opcode == mipsPkg::OP_BGTZ);
    assign j       = (opcode == mipsPkg::OP_J);
    assign jal     = (opcode == mipsPkg::OP_JAL);

    // Destination register
    always_comb begin
        if (jal) begin
            regAddr = mipsPkg::REG_RA;
        end else if (calcR) begin
            regAddr = rd;
        end else begin
            regAddr = rt;
        end
    end

    // Writes to $0 are dropped here so no stage ever sees them
    assign regWrite = (calcR || calcI || lui || load || jal) && (regAddr != 5'd0);

    // ALU operation with add as the fallback for address math
    always_comb begin
        if (calcR && funct == mipsPkg::FN_SUBU) begin
            aluOp = mipsPkg::ALU_SUB;
        end else if (calcI) begin
            aluOp = mipsPkg::ALU_OR;
        end else if (lui) begin
            aluOp = mipsPkg::ALU_LUI;
        end else begin
            aluOp = mipsPkg::ALU_ADD;
        end
    end

    assign opKnown = special || calcI || lui || load || store || beq || bgtz || j || jal;

    // Unsupported opcode in a real instruction word
    always_comb begin
        if (!$isunknown(instr) && instr != mipsPkg::INSTR_NOP) begin
            assert (opKnown)
                else $error("instrDecoder: unknown opcode %b in %h", instr[31:26], instr);
        end
    end

endmodule

// File: verilog/hazardUnit.sv
`timescale 1ns/1ns

module hazardUnit (
    input  logic [31:0] dInstr,
    input  logic [31:0] eInstr,
    input  logic [31:0] mInstr,
    output logic        stall
);

    // Decode stage consumer
    logic [4:0] dRs;
    logic [4:0] dRt;
    logic       dCalcR;
    logic       dCalcI;
    logic       dLoad;
    logic       dStore;
    logic       dBeq;
    logic       dBgtz;
    logic       dJr;
    logic [1:0] tuseRs;
    logic [1:0] tuseRt;

    // Execute stage producer
    logic [4:0] eRegAddr;
    logic       eRegWrite;
    logic       eCalcR;
    logic       eCalcI;
    logic       eLoad;
    logic       eLui;
    logic       eJal;
    logic [1:0] eTnew;

    // Memory stage producer
    logic [4:0] mRegAddr;
    logic       mRegWrite;
    logic       mLoad;
    logic [1:0] mTnew;

    logic       stallRs;
    logic       stallRt;

    instrDecoder dDec (
        .instr(dInstr), .rs(dRs), .rt(dRt), .regAddr(), .regWrite(),
        .calcR(dCalcR), .calcI(dCalcI), .load(dLoad), .store(dStore), .lui(),
        .beq(dBeq), .bgtz(dBgtz), .j(), .jal(), .jr(dJr), .aluOp()
    );

    instrDecoder eDec (
        .instr(eInstr), .rs(), .rt(), .regAddr(eRegAddr), .regWrite(eRegWrite),
        .calcR(eCalcR), .calcI(eCalcI), .load(eLoad), .store(), .lui(eLui),
        .beq(), .bgtz(), .j(), .jal(eJal), .jr(), .aluOp()
    );

    instrDecoder mDec (
        .instr(mInstr), .rs(), .rt(), .regAddr(mRegAddr), .regWrite(mRegWrite),
        .calcR(), .calcI(), .load(mLoad), .store(), .lui(),
        .beq(), .bgtz(), .j(), .jal(), .jr(), .aluOp()
    );

    //////////////////////////////////////////////////
    // Static use times of the decode instruction
    //////////////////////////////////////////////////

    // Branch compare and jr read rs in decode itself
    assign tuseRs = (dBeq || dBgtz || dJr)                 ? mipsPkg::TUSE_BRANCH :
                    (dCalcR || dCalcI || dLoad || dStore)   ? mipsPkg::TUSE_ALU :
                    mipsPkg::TUSE_NONE;

    // Store data is only needed in the memory stage
    assign tuseRt = dBeq   ? mipsPkg::TUSE_BRANCH :
                    dCalcR ? mipsPkg::TUSE_ALU :
                    dStore ? mipsPkg::TUSE_STORE :
                    mipsPkg::TUSE_NONE;

    //////////////////////////////////////////////////
    // Dynamic ready times of the producers
    //////////////////////////////////////////////////

    // jal link value travels with the ALU results
    assign eTnew = (eCalcR || eCalcI || eLui || eJal) ? mipsPkg::TNEW_ALU :
                   eLoad ? mipsPkg::TNEW_LOAD :
                   2'd0;

    // One stage later the load still owes one cycle
    assign mTnew = mLoad ? (mipsPkg::TNEW_LOAD - 2'd1) : 2'd0;

    // Stall only if the value would arrive after its use
    assign stallRs = (dRs != 5'd0) &&
                     ((eRegWrite && dRs == eRegAddr && tuseRs < eTnew) ||
                      (mRegWrite && dRs == mRegAddr && tuseRs < mTnew));

    assign stallRt = (dRt != 5'd0) &&
                     ((eRegWrite && dRt == eRegAddr && tuseRt < eTnew) ||
                      (mRegWrite && dRt == mRegAddr && tuseRt < mTnew));

    assign stall = stallRs || stallRt;

    // A stall needs a real instruction word downstream
    always_comb begin
        if (!$isunknown({stall, eInstr, mInstr})) begin
            assert (!stall || eInstr != mipsPkg::INSTR_NOP || mInstr != mipsPkg::INSTR_NOP)
                else $error("hazardUnit: stall while execute and memory hold bubbles");
        end
    end

endmodule

// File: verilog/regFile.sv
`timescale 1ns/1ns

module regFile (
    input  logic        clk,
    input  logic        rstN,
    input  logic        we,
    input  logic [4:0]  wAddr,
    input  logic [31:0] wData,
    input  logic [4:0]  rAddr1,
    input  logic [4:0]  rAddr2,
    output logic [31:0] rData1,
    output logic [31:0] rData2
);

    logic [31:0] regs [32];

    // $0 is never written
    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= 32'd0;
            end
        end else if (we && wAddr != 5'd0) begin
            regs[wAddr] <= wData;
        end
    end

    // Writeback data bypassed to a same-cycle read
    assign rData1 = (rAddr1 == 5'd0)           ? 32'd0 :
                    (we && wAddr == rAddr1)    ? wData : regs[rAddr1];
    assign rData2 = (rAddr2 == 5'd0)           ? 32'd0 :
                    (we && wAddr == rAddr2)    ? wData : regs[rAddr2];

endmodule

// File: verilog/aluUnit.sv
`timescale 1ns/1ns

module aluUnit (
    input  mipsPkg::aluOpE op,
    input  logic [31:0]    a,
    input  logic [31:0]    b,
    output logic [31:0]    y
);

    // b already carries the extended immediate for I-type
    always_comb begin
        case (op)
            mipsPkg::ALU_ADD: begin
                // addu and lw/sw address
                y = a + b;
            end
            mipsPkg::ALU_SUB: begin
                y = a - b;
            end
            mipsPkg::ALU_OR: begin
                y = a | b;
            end
            mipsPkg::ALU_LUI: begin
                // Immediate into upper half
                y = {b[15:0], 16'h0000};
            end
            default: begin
                y = a + b;
            end
        endcase
    end

endmodule

// File: verilog/dataMem.sv
`timescale 1ns/1ns

module dataMem (
    input  logic        clk,
    input  logic        rstN,
    input  logic        we,
    input  logic [31:0] addr,
    input  logic [31:0] wData,
    output logic [31:0] rData
);

    logic [31:0] mem [mipsPkg::DMEM_WORDS];
    logic [5:0]  index;

    // Word index with the upper address bits ignored
    assign index = addr[7:2];

    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < mipsPkg::DMEM_WORDS; i++) begin
                mem[i] <= 32'd0;
            end
        end else if (we) begin
            mem[index] <= wData;
        end
    end

    // Asynchronous read for the load in the memory stage
    assign rData = mem[index];

    // Only whole-word stores exist
    assert property (@(posedge clk) disable iff (!rstN) we |-> addr[1:0] == 2'b00)
        else $error("dataMem: unaligned store to %h", addr);

endmodule

// File: verilog/mipsPipe.sv
`timescale 1ns/1ns

module mipsPipe (
    input  logic        clk,
    input  logic        rstN,
    input  logic [31:0] instr,
    output logic [31:0] instrAddr,
    output logic        regWe,
    output logic [4:0]  regWaddr,
    output logic [31:0] regWdata,
    output logic        memWe,
    output logic [31:0] memAddr,
    output logic [31:0] memWdata
);

    logic [31:0] pc;
    logic [31:0] nextPc;
    logic        stall;

    // Decode stage
    logic [31:0] dInstr;
    logic [31:0] dPc;
    logic [31:0] dPcPlus4;
    logic [4:0]  dRs;
    logic [4:0]  dRt;
    logic        dBeq;
    logic        dBgtz;
    logic        dJ;
    logic        dJal;
    logic        dJr;
    logic [31:0] rfData1;
    logic [31:0] rfData2;
    logic [31:0] dRsVal;
    logic [31:0] dRtVal;
    logic        branchTaken;

    // Execute stage
    logic [31:0]    eInstr;
    logic [31:0]    ePc;
    logic [31:0]    eRsVal;
    logic [31:0]    eRtVal;
    logic [4:0]     eRs;
    logic [4:0]     eRt;
    logic [4:0]     eRegAddr;
    logic           eRegWrite;
    logic           eCalcR;
    logic           eCalcI;
    logic           eLoad;
    logic           eStore;
    logic           eJal;
    mipsPkg::aluOpE eAluOp;
    logic [31:0]    eRsFwd;
    logic [31:0]    eRtFwd;
    logic [31:0]    eImm;
    logic [31:0]    aluY;
    logic [31:0]    eResult;

    // Memory stage
    logic [31:0] mInstr;
    logic [31:0] mResult;
    logic [31:0] mRtVal;
    logic [4:0]  mRegAddr;
    logic        mRegWrite;
    logic        mLoad;
    logic        mStore;
    logic [31:0] mStoreData;
    logic [31:0] memRData;

    // Writeback stage
    logic [4:0]  wRegAddr;
    logic        wRegWrite;
    logic [31:0] wData;

    // Youngest writer wins and $0 is never forwarded
    function automatic logic [31:0] forward(
        input logic [4:0]  src,
        input logic [31:0] regVal,
        input logic        mWr,
        input logic [4:0]  mDst,
        input logic [31:0] mVal,
        input logic        wWr,
        input logic [4:0]  wDst,
        input logic [31:0] wVal
    );
        logic [31:0] val;
        val = regVal;
        if (wWr && wDst == src && src != 5'd0) begin
            val = wVal;
        end
        if (mWr && mDst == src && src != 5'd0) begin
            val = mVal;
        end
        return val;
    endfunction

    hazardUnit hazard (
        .dInstr(dInstr),
        .eInstr(eInstr),
        .mInstr(mInstr),
        .stall(stall)
    );

    //////////////////////////////////////////////////
    // Fetch
    //////////////////////////////////////////////////

    assign instrAddr = pc;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            pc     <= mipsPkg::RESET_PC;
            dInstr <= mipsPkg::INSTR_NOP;
        end else if (!stall) begin
            pc     <= nextPc;
            dInstr <= instr;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            dPc <= pc;
        end
    end

    //////////////////////////////////////////////////
    // Decode, branch resolve and register read
    //////////////////////////////////////////////////

    instrDecoder dDec (
        .instr(dInstr), .rs(dRs), .rt(dRt), .regAddr(), .regWrite(),
        .calcR(), .calcI(), .load(), .store(), .lui(),
        .beq(dBeq), .bgtz(dBgtz), .j(dJ), .jal(dJal), .jr(dJr), .aluOp()
    );

    regFile regs (
        .clk(clk), .rstN(rstN), .we(wRegWrite), .wAddr(wRegAddr), .wData(wData),
        .rAddr1(dRs), .rAddr2(dRt), .rData1(rfData1), .rData2(rfData2)
    );

    // Writeback results arrive through the register file bypass
    // A load in memory gives only its address here, fixed in execute or by a stall
    assign dRsVal = forward(dRs, rfData1, mRegWrite, mRegAddr, mResult,
                            1'b0, 5'd0, 32'd0);
    assign dRtVal = forward(dRt, rfData2, mRegWrite, mRegAddr, mResult,
                            1'b0, 5'd0, 32'd0);

    assign dPcPlus4 = dPc + 32'd4;

    // bgtz is signed greater than zero
    assign branchTaken = (dBeq && dRsVal == dRtVal) ||
                         (dBgtz && !dRsVal[31] && dRsVal != 32'd0);

    // Target for the fetch after the delay slot
    always_comb begin
        if (dJr) begin
            nextPc = dRsVal;
        end else if (dJ || dJal) begin
            nextPc = {dPcPlus4[31:28], dInstr[25:0], 2'b00};
        end else if (branchTaken) begin
            nextPc = dPcPlus4 + {{14{dInstr[15]}}, dInstr[15:0], 2'b00};
        end else begin
            nextPc = pc + 32'd4;
        end
    end

    // Bubble into execute while decode waits
    always_ff @(posedge clk) begin
        if (!rstN || stall) begin
            eInstr <= mipsPkg::INSTR_NOP;
        end else begin
            eInstr <= dInstr;
        end
    end

    always_ff @(posedge clk) begin
        ePc    <= dPc;
        eRsVal <= dRsVal;
        eRtVal <= dRtVal;
    end

    //////////////////////////////////////////////////
    // Execute
    //////////////////////////////////////////////////

    instrDecoder eDec (
        .instr(eInstr), .rs(eRs), .rt(eRt), .regAddr(eRegAddr), .regWrite(eRegWrite),
        .calcR(eCalcR), .calcI(eCalcI), .load(eLoad), .store(eStore), .lui(),
        .beq(), .bgtz(), .j(), .jal(eJal), .jr(), .aluOp(eAluOp)
    );

    assign eRsFwd = forward(eRs, eRsVal, mRegWrite, mRegAddr, mResult,
                            wRegWrite, wRegAddr, wData);
    assign eRtFwd = forward(eRt, eRtVal, mRegWrite, mRegAddr, mResult,
                            wRegWrite, wRegAddr, wData);

    // Zero extend for ori and sign extend for offsets
    assign eImm = eCalcI ? {16'h0000, eInstr[15:0]} : {{16{eInstr[15]}}, eInstr[15:0]};

    aluUnit alu (
        .op(eAluOp),
        .a(eRsFwd),
        .b(eCalcR ? eRtFwd : eImm),
        .y(aluY)
    );

    // Link skips the delay slot
    assign eResult = eJal ? (ePc + 32'd8) : aluY;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            mInstr    <= mipsPkg::INSTR_NOP;
            mRegWrite <= 1'b0;
            mLoad     <= 1'b0;
            mStore    <= 1'b0;
        end else begin
            mInstr    <= eInstr;
            mRegWrite <= eRegWrite;
            mLoad     <= eLoad;
            mStore    <= eStore;
        end
    end

    always_ff @(posedge clk) begin
        mResult  <= eResult;
        mRtVal   <= eRtFwd;
        mRegAddr <= eRegAddr;
    end

    //////////////////////////////////////////////////
    // Memory and writeback
    //////////////////////////////////////////////////

    // Store data late fix from writeback covers a load right before the store
    assign mStoreData = forward(mInstr[20:16], mRtVal, 1'b0, 5'd0, 32'd0,
                                wRegWrite, wRegAddr, wData);

    dataMem dmem (
        .clk(clk), .rstN(rstN), .we(mStore), .addr(mResult),
        .wData(mStoreData), .rData(memRData)
    );

    assign memWe    = mStore;
    assign memAddr  = mResult;
    assign memWdata = mStoreData;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            wRegWrite <= 1'b0;
        end else begin
            wRegWrite <= mRegWrite;
        end
    end

    always_ff @(posedge clk) begin
        wRegAddr <= mRegAddr;
        wData    <= mLoad ? memRData : mResult;
    end

    assign regWe    = wRegWrite;
    assign regWaddr = wRegAddr;
    assign regWdata = wData;

endmodule

// File: testbench/clockGen.sv
`timescale 1ns/1ns

module clockGen (
    output logic clk,
    output logic rstN
);

    localparam int HALF_PERIOD   = 20;
    localparam int RESET_CYCLES  = 16;
    localparam int RELEASE_DELAY = 2;

    // 40 ns free-running clock
    initial begin
        clk = 1'b0;
        forever begin
            #HALF_PERIOD clk = ~clk;
        end
    end

    // Reset low from time zero until just after a rising edge
    initial begin
        rstN = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #RELEASE_DELAY rstN = 1'b1;
    end

endmodule

// File: testbench/wbChecker.sv
`timescale 1ns/1ns

module wbChecker (
    input  logic        clk,
    input  logic        rstN,
    input  logic [31:0] rom [256],
    input  logic [31:0] instrAddr,
    input  logic        regWe,
    input  logic [4:0]  regWaddr,
    input  logic [31:0] regWdata,
    input  logic        memWe,
    input  logic [31:0] memAddr,
    input  logic [31:0] memWdata,
    output logic        done,
    output int          regErrors,
    output int          memErrors,
    output int          otherErrors
);

    localparam int MAX_STEPS = 1000;

    // Expected writes in program order with the producer pc
    logic [4:0]  expRegAddr [$];
    logic [31:0] expRegData [$];
    logic [31:0] expRegPc   [$];
    logic [31:0] expMemAddr [$];
    logic [31:0] expMemData [$];
    logic [31:0] expMemPc   [$];

    //////////////////////////////////////////////////
    // Reference ISA model
    //////////////////////////////////////////////////

    // One instruction per step with the branch target taken after the delay slot
    function automatic logic buildExpectedWrites(output logic [31:0] endPc);
        logic [31:0] gpr [32];
        logic [31:0] dmem [mipsPkg::DMEM_WORDS];
        logic [31:0] pc;
        logic [31:0] npc;
        logic [31:0] pcPlus4;
        logic [31:0] target;
        logic [31:0] ir;
        logic [31:0] rsVal;
        logic [31:0] rtVal;
        logic [31:0] simm;
        logic [31:0] addr;
        logic [31:0] result;
        logic [4:0]  dst;
        logic        writes;
        endPc = 32'hffff_ffff;
        for (int i = 0; i < 32; i++) begin
            gpr[i] = 32'd0;
        end
        for (int i = 0; i < mipsPkg::DMEM_WORDS; i++) begin
            dmem[i] = 32'd0;
        end
        pc  = mipsPkg::RESET_PC;
        npc = pc + 32'd4;
        for (int step = 0; step < MAX_STEPS; step++) begin
            ir      = rom[pc[9:2]];
            rsVal   = gpr[ir[25:21]];
            rtVal   = gpr[ir[20:16]];
            simm    = {{16{ir[15]}}, ir[15:0]};
            addr    = rsVal + simm;
            pcPlus4 = pc + 32'd4;
            target  = npc + 32'd4;
            dst     = ir[20:16];
            result  = 32'd0;
            writes  = 1'b0;
            case (ir[31:26])
                // SPECIAL group where the function field picks addu, subu or jr
                6'h00: begin
                    dst = ir[15:11];
                    if (ir[5:0] == 6'h21) begin
                        result = rsVal + rtVal;
                        writes = 1'b1;
                    end else if (ir[5:0] == 6'h23) begin
                        result = rsVal - rtVal;
                        writes = 1'b1;
                    end else if (ir[5:0] == 6'h08) begin
                        target = rsVal;
                    end
                end
                // ori with zero-extended immediate
                6'h0d: begin
                    result = rsVal | {16'h0000, ir[15:0]};
                    writes = 1'b1;
                end
                // lui
                6'h0f: begin
                    result = {ir[15:0], 16'h0000};
                    writes = 1'b1;
                end
                // lw wraps inside the 256-byte window
                6'h23: begin
                    result = dmem[addr[7:2]];
                    writes = 1'b1;
                end
                // sw
                6'h2b: begin
                    dmem[addr[7:2]] = rtVal;
                    expMemAddr.push_back(addr);
                    expMemData.push_back(rtVal);
                    expMemPc.push_back(pc);
                end
                // beq
                6'h04: begin
                    if (rsVal == rtVal) begin
                        target = pcPlus4 + (simm << 2);
                    end
                    // Always-taken branch onto itself closes the program
                    if (ir[25:21] == ir[20:16] && target == pc) begin
                        endPc = pc;
                        return 1'b1;
                    end
                end
                // bgtz with signed compare
                6'h07: begin
                    if ($signed(rsVal) > 0) begin
                        target = pcPlus4 + (simm << 2);
                    end
                end
                // j
                6'h02: begin
                    target = {pcPlus4[31:28], ir[25:0], 2'b00};
                end
                // jal links past the delay slot
                6'h03: begin
                    target = {pcPlus4[31:28], ir[25:0], 2'b00};
                    result = pc + 32'd8;
                    dst    = 5'd31;
                    writes = 1'b1;
                end
                default: begin
                end
            endcase
            // $0 stays zero and shows no write
            if (writes && dst != 5'd0) begin
                gpr[dst] = result;
                expRegAddr.push_back(dst);
                expRegData.push_back(result);
                expRegPc.push_back(pc);
            end
            pc  = npc;
            npc = target;
        end
        return 1'b0;
    endfunction

    //////////////////////////////////////////////////
    // Write comparison
    //////////////////////////////////////////////////

    // Write ports sampled on the falling edge
    initial begin : compareWrites
        logic        built;
        logic        loopSeen;
        logic [31:0] loopPc;
        int          regIndex;
        int          memIndex;
        logic [4:0]  wantReg;
        logic [31:0] wantAddr;
        logic [31:0] wantData;
        logic [31:0] wantPc;
        built       = 1'b0;
        loopSeen    = 1'b0;
        loopPc      = 32'hffff_ffff;
        regIndex    = 0;
        memIndex    = 0;
        done        = 1'b0;
        regErrors   = 0;
        memErrors   = 0;
        otherErrors = 0;
        forever begin
            @(negedge clk);
            if (!rstN) begin
                // ROM is loaded and patched by now
                if (!built) begin
                    built = 1'b1;
                    if (!buildExpectedWrites(loopPc)) begin
                        $display("Reference model found no final self-loop in %0d steps",
                                 MAX_STEPS);
                        otherErrors++;
                    end
                end
            end else begin
                if (regWe) begin
                    if (expRegAddr.size() == 0) begin
                        $display("Register write to $%0d = %h came after all expected writes",
                                 regWaddr, regWdata);
                        regErrors++;
                    end else begin
                        wantReg  = expRegAddr.pop_front();
                        wantData = expRegData.pop_front();
                        wantPc   = expRegPc.pop_front();
                        if (regWaddr !== wantReg || regWdata !== wantData) begin
                            $display("[ERROR] regWrite %0d pc %h expected $%0d=%h actual $%0d=%h",
                                     regIndex, wantPc, wantReg, wantData, regWaddr, regWdata);
                            regErrors++;
                        end
                        regIndex++;
                    end
                end
                if (memWe) begin
                    if (expMemAddr.size() == 0) begin
                        $display("Store to %h = %h came after all expected stores",
                                 memAddr, memWdata);
                        memErrors++;
                    end else begin
                        wantAddr = expMemAddr.pop_front();
                        wantData = expMemData.pop_front();
                        wantPc   = expMemPc.pop_front();
                        if (memAddr !== wantAddr || memWdata !== wantData) begin
                            $display("[ERROR] memWrite %0d pc %h expected [%h]=%h actual [%h]=%h",
                                     memIndex, wantPc, wantAddr, wantData, memAddr, memWdata);
                            memErrors++;
                        end
                        memIndex++;
                    end
                end
                // Done once the self-loop is fetched and nothing is owed
                if (instrAddr === loopPc) begin
                    loopSeen = 1'b1;
                end
                done = loopSeen && expRegAddr.size() == 0 && expMemAddr.size() == 0;
            end
        end
    end

endmodule

// File: testbench/mipsPipeTb.sv
`timescale 1ns/1ns

module mipsPipeTb;

    localparam int ROM_WORDS   = 256;
    localparam int RAND_WORDS  = 6;
    localparam int RESET_LIMIT = 40;
    localparam int RUN_LIMIT   = 2000;

    logic        clk;
    logic        rstN;
    logic [31:0] instr;
    logic [31:0] instrAddr;
    logic        regWe;
    logic [4:0]  regWaddr;
    logic [31:0] regWdata;
    logic        memWe;
    logic [31:0] memAddr;
    logic [31:0] memWdata;
    logic [31:0] rom [ROM_WORDS];
    logic        done;
    int          regErrors;
    int          memErrors;
    int          otherErrors;
    int          timeouts;

    clockGen clkGen (
        .clk(clk),
        .rstN(rstN)
    );

    // Instruction ROM answering in the same cycle
    assign instr = rom[instrAddr[9:2]];

    mipsPipe i_dut (
        .clk(clk), .rstN(rstN), .instr(instr), .instrAddr(instrAddr),
        .regWe(regWe), .regWaddr(regWaddr), .regWdata(regWdata),
        .memWe(memWe), .memAddr(memAddr), .memWdata(memWdata)
    );

    wbChecker wbCheck (
        .clk(clk), .rstN(rstN), .rom(rom), .instrAddr(instrAddr),
        .regWe(regWe), .regWaddr(regWaddr), .regWdata(regWdata),
        .memWe(memWe), .memAddr(memAddr), .memWdata(memWdata),
        .done(done), .regErrors(regErrors), .memErrors(memErrors),
        .otherErrors(otherErrors)
    );

    initial begin : runControl
        int cycles;
        timeouts = 0;
        for (int i = 0; i < ROM_WORDS; i++) begin
            rom[i] = 32'h0000_0000;
        end
        $readmemh("testbench/program.hex", rom);
        void'($urandom(32'haf4f_86f4));
        // Leading ori words take random immediates
        for (int i = 0; i < RAND_WORDS; i++) begin
            rom[i][15:0] = 16'($urandom());
        end

        cycles = 0;
        while (rstN !== 1'b1 && cycles < RESET_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        if (rstN !== 1'b1) begin
            $display("Timeout: reset was still active after %0d cycles", RESET_LIMIT);
            timeouts++;
        end else begin
            cycles = 0;
            while (!done && cycles < RUN_LIMIT) begin
                @(posedge clk);
                cycles++;
            end
            if (!done) begin
                $display("Timeout: program did not finish within %0d cycles", RUN_LIMIT);
                timeouts++;
            end
        end

        $display("Errors: register writes %0d, memory writes %0d, other %0d",
                 regErrors, memErrors, otherErrors + timeouts);
        if (regErrors + memErrors + otherErrors + timeouts == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// File: testbench/program.hex
// One instruction word per line, starting at word address 0
// Words 00 to 05 are ori with immediates replaced at run time
34100000 // 00 ori  $16,$0,rand
34110000 // 01 ori  $17,$0,rand
34120000 // 02 ori  $18,$0,rand
34130000 // 03 ori  $19,$0,rand
34140000 // 04 ori  $20,$0,rand
34150000 // 05 ori  $21,$0,rand
34010010 // 06 ori  $1,$0,0x10
34020005 // 07 ori  $2,$0,5
3C038000 // 08 lui  $3,0x8000
34040040 // 09 ori  $4,$0,0x40   data base
02112821 // 0a addu $5,$16,$17  back-to-back ALU chain
00B23023 // 0b subu $6,$5,$18
00C53821 // 0c addu $7,$6,$5
34E81234 // 0d ori  $8,$7,0x1234
3C09ABCD // 0e lui  $9,0xabcd
01285021 // 0f addu $10,$9,$8
AC8A0000 // 10 sw   $10,0($4)   data from ALU just before
AC870004 // 11 sw   $7,4($4)
8C8B0000 // 12 lw   $11,0($4)
01626021 // 13 addu $12,$11,$2  load-use
8C8D0004 // 14 lw   $13,4($4)
AC8D0008 // 15 sw   $13,8($4)   data from load just before
8C8E0008 // 16 lw   $14,8($4)
11C70002 // 17 beq  $14,$7,+2   load-branch, taken
340F0024 // 18 ori  $15,$0,0x24 delay slot
340F0BAD // 19 ori  $15,$0,0xbad skipped
10220002 // 1a beq  $1,$2,+2    not taken
0022B021 // 1b addu $22,$1,$2   delay slot
34170028 // 1c ori  $23,$0,0x28
1C200002 // 1d bgtz $1,+2       taken
02C2B023 // 1e subu $22,$22,$2  delay slot
34160BAD // 1f ori  $22,$0,0xbad skipped
1C600002 // 20 bgtz $3,+2       not taken
34180033 // 21 ori  $24,$0,0x33 delay slot
34190034 // 22 ori  $25,$0,0x34
00220021 // 23 addu $0,$1,$2    no write
34001234 // 24 ori  $0,$0,0x1234 no write
8C800000 // 25 lw   $0,0($4)    no write
0C000032 // 26 jal  0x32
341A0039 // 27 ori  $26,$0,0x39 delay slot
03E0E021 // 28 addu $28,$31,$0  return point
0C000036 // 29 jal  0x36
375A0100 // 2a ori  $26,$26,0x100 delay slot
0800002E // 2b j    0x2e        second return point
0021E821 // 2c addu $29,$1,$1   delay slot
341D0BAD // 2d ori  $29,$0,0xbad skipped
1000FFFF // 2e beq  $0,$0,-1    final self-loop
00000000 // 2f nop
00000000 // 30 nop
00000000 // 31 nop
0202F021 // 32 addu $30,$16,$2  first subroutine
03E00008 // 33 jr   $31
37180100 // 34 ori  $24,$24,0x100 delay slot
00000000 // 35 nop
AC9F000C // 36 sw   $31,12($4)  second subroutine
8C9B000C // 37 lw   $27,12($4)
03600008 // 38 jr   $27         stalls on the load
037EC821 // 39 addu $25,$27,$30 delay slot
34190BAD // 3a ori  $25,$0,0xbad never reached

// File: mipsPipe.f
verilog/mipsPkg.sv
verilog/instrDecoder.sv
verilog/hazardUnit.sv
verilog/regFile.sv
verilog/aluUnit.sv
verilog/dataMem.sv
verilog/mipsPipe.sv
testbench/clockGen.sv
testbench/wbChecker.sv
testbench/mipsPipeTb.sv

// File: run.sh
#!/bin/sh
# Build with Verilator, run, and judge the result from the simulation log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module mipsPipeTb -f mipsPipe.f -o mipsPipeSim \
    && ./obj_dir/mipsPipeSim | tee sim.log \
    && grep -q '^\*\*\* PASSED \*\*\*$' sim.log \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }
